// ==== tb.f ====
hw/rename_pkg.sv
hw/rename_map_table.sv
hw/free_list.sv
hw/arch_map_table.sv
hw/rename_stage.sv
dv/tb_clk_gen.sv
dv/tb_rename_stage.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - files:
      - hw/rename_pkg.sv
      - hw/rename_map_table.sv
      - hw/free_list.sv
      - hw/arch_map_table.sv
      - hw/rename_stage.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_rename_stage.sv

// ==== dv/tb_rename_stage.sv ====
// Testbench for the rename stage with random groups and commits checked against a model
`timescale 1ns/1ps

module tb_rename_stage;
  import rename_pkg::*;

  localparam int unsigned DW         = DEFAULT_DECODE_WIDTH;
  localparam int unsigned PREG_W     = $clog2(DEFAULT_PHY_REG_NUM);
  localparam int unsigned NUM_CYCLES = 4000;                      // Random cycles
  localparam int unsigned TIMEOUT_NS = (NUM_CYCLES + 10) * 20 + 500;

  typedef struct packed {
    logic [PREG_W-1:0] psrc0;
    logic [PREG_W-1:0] psrc1;
    logic [PREG_W-1:0] ppdst;
    logic [PREG_W-1:0] pdst;
  } rsp_t;

  // In-flight entry standing in for the ROB
  typedef struct packed {
    int dest;
    int pdst;
    int ppdst;
  } inflight_t;

  logic                 clk;
  logic                 rst_n;
  logic                 rename_fire;
  rename_req_t [DW-1:0] rename_req;
  logic [PREG_W:0]      free_credits;
  rsp_t [DW-1:0]        rename_rsp;
  commit_t [DW-1:0]     commit;
  logic                 flush;

  // ============================================================
  // Reference model state
  // ============================================================
  int          spec_map [ARCH_REG_NUM];
  int          arch_map [ARCH_REG_NUM];
  int          free_q [$];      // Index 0 is the committed head
  int          spec_off;        // Allocated past the committed head
  inflight_t   inflight_q [$];  // Oldest first
  logic [31:0] rng_state;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(4)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  rename_stage #(
    .DECODE_WIDTH (DEFAULT_DECODE_WIDTH),
    .PHY_REG_NUM  (DEFAULT_PHY_REG_NUM)
  ) i_rename_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .rename_fire_i  (rename_fire),
    .rename_req_i   (rename_req),
    .free_credits_o (free_credits),
    .rename_rsp_o   (rename_rsp),
    .commit_i       (commit),
    .flush_i        (flush)
  );

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic set_idle();
    rename_fire = 1'b0;
    rename_req  = '0;
    commit      = '0;
    flush       = 1'b0;
  endtask

  // Small register ranges now and then so lanes collide
  task automatic random_group(input int budget, output rename_req_t [DW-1:0] grp);
    logic [31:0] r;
    int          used;
    used = 0;
    for (int l = 0; l < DW; l++) begin
      r = next_rand();
      grp[l].valid = (r[1:0] != 2'b00) && (used < budget);  // Never above credits
      grp[l].src0  = r[30] ? areg_t'(r[4:2]) : r[6:2];
      grp[l].src1  = r[29] ? areg_t'(r[9:7]) : r[11:7];
      grp[l].dest  = r[31] ? areg_t'(r[14:12]) : r[16:12];
      if (grp[l].valid) begin
        used++;
      end
    end
  endtask

  // ============================================================
  // Stimulus with model update
  // ============================================================
  // Lanes renamed one after another like sequential decode
  task automatic fire_group(input rename_req_t [DW-1:0] grp);
    int        work [ARCH_REG_NUM];
    int        alloc;
    inflight_t ent;
    work        = spec_map;
    alloc       = 0;
    rename_fire = 1'b1;
    rename_req  = grp;
    #1;  // Let the lookup settle
    for (int l = 0; l < DW; l++) begin
      check_val($sformatf("rename_rsp_o[%0d].psrc0", l), int'(rename_rsp[l].psrc0),
                work[grp[l].src0]);
      check_val($sformatf("rename_rsp_o[%0d].psrc1", l), int'(rename_rsp[l].psrc1),
                work[grp[l].src1]);
      check_val($sformatf("rename_rsp_o[%0d].ppdst", l), int'(rename_rsp[l].ppdst),
                work[grp[l].dest]);
      if (grp[l].valid) begin
        ent.dest  = int'(grp[l].dest);
        ent.pdst  = free_q[spec_off + alloc];  // Next free in allocation order
        ent.ppdst = work[grp[l].dest];
        check_val($sformatf("rename_rsp_o[%0d].pdst", l), int'(rename_rsp[l].pdst), ent.pdst);
        inflight_q.push_back(ent);
        work[grp[l].dest] = ent.pdst;
        alloc++;
      end
    end
    spec_map = work;
    spec_off = spec_off + alloc;
  endtask

  task automatic commit_oldest(input int n);
    commit_t [DW-1:0] lanes;
    inflight_t        ent;
    lanes = '0;
    for (int l = 0; l < n; l++) begin
      ent                = inflight_q.pop_front();
      lanes[l].valid     = 1'b1;
      lanes[l].dest      = areg_t'(ent.dest);
      lanes[l].preg      = PREG_W_MAX'(ent.pdst);
      lanes[l].old_preg  = PREG_W_MAX'(ent.ppdst);
      arch_map[ent.dest] = ent.pdst;
      void'(free_q.pop_front());     // Committed head moves on
      free_q.push_back(ent.ppdst);   // Old mapping freed at tail
    end
    spec_off = spec_off - n;
    commit   = lanes;
  endtask

  // Group fired alongside the flush must be dropped
  task automatic flush_map();
    rename_req_t [DW-1:0] grp;
    random_group(DW, grp);
    rename_fire = 1'b1;
    rename_req  = grp;
    flush       = 1'b1;
    spec_map    = arch_map;
    spec_off    = 0;
    inflight_q.delete();
  endtask

  initial begin : stimulus
    rename_req_t [DW-1:0] grp;
    logic [31:0]          r;
    int                   n;
    set_idle();
    rng_state = 32'd65;
    spec_off  = 0;
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      spec_map[i] = i;  // Identity after reset
      arch_map[i] = i;
    end
    for (int i = ARCH_REG_NUM; i < DEFAULT_PHY_REG_NUM; i++) begin
      free_q.push_back(i);
    end
    @(posedge rst_n);

    // Directed RAW and WAW on r5 right after reset
    @(negedge clk);
    check_val("free_credits_o", int'(free_credits), DEFAULT_PHY_REG_NUM - ARCH_REG_NUM);
    grp[0] = '{1'b1, 5'd3, 5'd7, 5'd5};
    grp[1] = '{1'b1, 5'd5, 5'd31, 5'd5};
    fire_group(grp);
    check_val("rename_rsp_o[0].pdst", int'(rename_rsp[0].pdst), 32);
    check_val("rename_rsp_o[1].pdst", int'(rename_rsp[1].pdst), 33);
    check_val("rename_rsp_o[1].psrc0", int'(rename_rsp[1].psrc0), 32);  // Forwarded
    check_val("rename_rsp_o[1].ppdst", int'(rename_rsp[1].ppdst), 32);
    @(negedge clk);
    set_idle();
    grp[0] = '{1'b0, 5'd5, 5'd5, 5'd0};
    grp[1] = '{1'b0, 5'd3, 5'd5, 5'd0};
    fire_group(grp);
    check_val("rename_rsp_o[0].psrc0", int'(rename_rsp[0].psrc0), 33);  // Last writer won

    // ============================================================
    // Random phase
    // ============================================================
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clk);
      set_idle();
      check_val("free_credits_o", int'(free_credits), free_q.size() - spec_off);
      r = next_rand();
      if (r[6:0] == 7'd0) begin
        flush_map();  // Rare
      end else if ((inflight_q.size() > 0) && (r[7] || (spec_off == free_q.size()))) begin
        n = r[8] ? DW : 1;
        if (n > inflight_q.size()) begin
          n = inflight_q.size();
        end
        commit_oldest(n);
      end else begin
        random_group(free_q.size() - spec_off, grp);
        fire_group(grp);
      end
    end
    @(negedge clk);
    set_idle();
    check_val("free_credits_o", int'(free_credits), free_q.size() - spec_off);
    $display("TEST PASSED");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish in its expected time");
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule : tb_rename_stage

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and active-low reset source for the rename stage
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // First rising edge at half period
  end

  initial begin
    rst_n_o = 1'b0;
    #(PERIOD_NS * RST_CYCLES) rst_n_o = 1'b1;  // Lands on a falling edge
  end

endmodule : tb_clk_gen

// ==== hw/rename_stage.sv ====
// Rename stage top joining speculative map, free list and committed map
`timescale 1ns/1ps

module rename_stage #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DEFAULT_DECODE_WIDTH,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::DEFAULT_PHY_REG_NUM,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM),
  localparam type preg_t              = logic [PREG_W-1:0],
  // Same layout as in rename_map_table
  localparam type rename_rsp_t = struct packed {
    preg_t psrc0;
    preg_t psrc1;
    preg_t ppdst;
    preg_t pdst;
  }
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // Rename request, one group per cycle
  input  logic                                        rename_fire_i,
  input  rename_pkg::rename_req_t [DECODE_WIDTH-1:0]  rename_req_i,
  output logic [PREG_W:0]                             free_credits_o,  // Credits for decoder
  output rename_rsp_t [DECODE_WIDTH-1:0]              rename_rsp_o,
  // Retirement and recovery
  input  rename_pkg::commit_t [DECODE_WIDTH-1:0]      commit_i,
  input  logic                                        flush_i
);
  import rename_pkg::*;

  if ((2 ** PREG_W != PHY_REG_NUM) || (PHY_REG_NUM <= ARCH_REG_NUM) || (PREG_W > PREG_W_MAX))
  begin : g_bad_params
    $error("PHY_REG_NUM must be a power of two above ARCH_REG_NUM and fit PREG_W_MAX");
  end

  flow_state_e              state;
  logic                     fire;          // Group accepted this cycle
  logic [DECODE_WIDTH-1:0]  dest_valid;
  logic [DECODE_WIDTH-1:0]  commit_valid;
  preg_t [DECODE_WIDTH-1:0] alloc_preg;    // Free list -> map table
  preg_t [ARCH_REG_NUM-1:0] arch_map;      // Committed map -> map table

  // ============================================================
  // Flow control
  // ============================================================
  assign state = flush_i ? RESTORE : RUN;
  assign fire  = rename_fire_i && (state == RUN);  // Group dropped on flush

  always_comb begin
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      dest_valid[l]   = rename_req_i[l].valid;
      commit_valid[l] = commit_i[l].valid;
    end
  end

  // ============================================================
  // Tables
  // ============================================================
  rename_map_table #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .PHY_REG_NUM  (PHY_REG_NUM)
  ) i_rename_map_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .rename_fire_i (fire),
    .req_i         (rename_req_i),
    .alloc_preg_i  (alloc_preg),
    .restore_i     (flush_i),
    .arch_map_i    (arch_map),
    .rsp_o         (rename_rsp_o)
  );

  free_list #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .PHY_REG_NUM  (PHY_REG_NUM)
  ) i_free_list (
    .clk            (clk),
    .rst_n          (rst_n),
    .rename_fire_i  (fire),
    .dest_valid_i   (dest_valid),
    .commit_i       (commit_i),
    .flush_i        (flush_i),
    .alloc_preg_o   (alloc_preg),
    .free_credits_o (free_credits_o)
  );

  arch_map_table #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .PHY_REG_NUM  (PHY_REG_NUM)
  ) i_arch_map_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit_i   (commit_i),
    .arch_map_o (arch_map)
  );

  // Restore would copy a stale committed map and head
  a_no_commit_on_flush : assert property (
    @(posedge clk) disable iff (!rst_n)
    flush_i |-> (commit_valid == '0)
  ) else $error("commit during flush");

endmodule : rename_stage

// ==== hw/arch_map_table.sv ====
// Committed register map, written by retirement and read whole on flush
`timescale 1ns/1ps

module arch_map_table #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DEFAULT_DECODE_WIDTH,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::DEFAULT_PHY_REG_NUM,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM),
  localparam type preg_t              = logic [PREG_W-1:0]
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  rename_pkg::commit_t [DECODE_WIDTH-1:0]  commit_i,
  output preg_t [rename_pkg::ARCH_REG_NUM-1:0]    arch_map_o  // Whole table for restore
);
  import rename_pkg::*;

  preg_t [ARCH_REG_NUM-1:0] map_q;
  logic                     preg_in_range;  // All committed pregs fit the table

  // ============================================================
  // Commit update
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        map_q[r] <= preg_t'(r);  // Identity, same as speculative map
      end
    end else begin
      // Lane order, younger lane overwrites
      for (int l = 0; l < DECODE_WIDTH; l++) begin
        if (commit_i[l].valid) begin
          map_q[commit_i[l].dest] <= commit_i[l].preg[PREG_W-1:0];
        end
      end
    end
  end

  assign arch_map_o = map_q;

  always_comb begin
    preg_in_range = 1'b1;
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      if (commit_i[l].valid && (commit_i[l].preg >= PHY_REG_NUM)) begin
        preg_in_range = 1'b0;
      end
    end
  end

  // ROB hands back pdst from rename, must be inside the physical file
  a_commit_preg_range : assert property (
    @(posedge clk) disable iff (!rst_n) preg_in_range
  ) else $error("committed preg outside physical register file");

endmodule : arch_map_table

// ==== hw/free_list.sv ====
// Circular free list of physical registers with credit count and flush rewind
`timescale 1ns/1ps

module free_list #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DEFAULT_DECODE_WIDTH,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::DEFAULT_PHY_REG_NUM,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM),
  localparam type preg_t              = logic [PREG_W-1:0],
  localparam type cnt_t               = logic [PREG_W:0]  // Extra wrap bit
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    rename_fire_i,  // Gated fire
  input  logic [DECODE_WIDTH-1:0]                 dest_valid_i,   // Lanes needing a preg
  input  rename_pkg::commit_t [DECODE_WIDTH-1:0]  commit_i,
  input  logic                                    flush_i,
  output preg_t [DECODE_WIDTH-1:0]                alloc_preg_o,
  output cnt_t                                    free_credits_o
);
  import rename_pkg::*;

  localparam int unsigned FREE_INIT = PHY_REG_NUM - ARCH_REG_NUM;  // Regs free after reset

  // Pointers wrap on PHY_REG_NUM so it has to be a power of two
  preg_t [PHY_REG_NUM-1:0]  fifo_q;
  cnt_t                     spec_head_q;  // Next to allocate
  cnt_t                     comm_head_q;  // Oldest not yet committed
  cnt_t                     tail_q;       // Next free slot for returns
  cnt_t                     alloc_cnt;
  cnt_t                     commit_cnt;
  cnt_t [DECODE_WIDTH-1:0]  alloc_off;    // Lane offset from spec head
  cnt_t [DECODE_WIDTH-1:0]  push_off;     // Lane offset from tail
  flow_state_e              state;

  assign state = flush_i ? RESTORE : RUN;

  // ============================================================
  // Lane packing
  // ============================================================
  always_comb begin
    alloc_cnt  = '0;
    commit_cnt = '0;
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      alloc_off[l] = alloc_cnt;   // Valid lanes before this one
      push_off[l]  = commit_cnt;
      alloc_cnt    = alloc_cnt + cnt_t'(dest_valid_i[l]);
      commit_cnt   = commit_cnt + cnt_t'(commit_i[l].valid);
    end
  end

  // Invalid lanes just see the next slot and never consume it
  always_comb begin
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      alloc_preg_o[l] = fifo_q[preg_t'(spec_head_q + alloc_off[l])];
    end
  end

  assign free_credits_o = tail_q - spec_head_q;

  // ============================================================
  // Pointers
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spec_head_q <= '0;
      comm_head_q <= '0;
      tail_q      <= cnt_t'(FREE_INIT);
    end else begin
      if (state == RESTORE) begin
        spec_head_q <= comm_head_q;  // Rewind speculative allocations
      end else if (rename_fire_i) begin
        spec_head_q <= spec_head_q + alloc_cnt;
      end
      comm_head_q <= comm_head_q + commit_cnt;  // One pop per committed dest
      tail_q      <= tail_q + commit_cnt;
    end
  end

  // Queue storage holding free pregs in allocation order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        fifo_q[i] <= preg_t'(i + ARCH_REG_NUM);  // 32, 33, ... in order
      end
    end else begin
      for (int l = 0; l < DECODE_WIDTH; l++) begin
        if (commit_i[l].valid) begin
          fifo_q[preg_t'(tail_q + push_off[l])] <= commit_i[l].old_preg[PREG_W-1:0];
        end
      end
    end
  end

  // Decoder may not send more dest writes than published credits
  a_credit_rule : assert property (
    @(posedge clk) disable iff (!rst_n)
    rename_fire_i |-> (alloc_cnt <= free_credits_o)
  ) else $error("rename group exceeds free credits");

  // Commits never return more than was ever handed out
  a_credit_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    free_credits_o <= cnt_t'(FREE_INIT)
  ) else $error("free credits above PHY_REG_NUM-ARCH_REG_NUM");

endmodule : free_list

// ==== hw/rename_map_table.sv ====
// Speculative rename map with in-group RAW/WAW handling and flush restore
`timescale 1ns/1ps

module rename_map_table #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DEFAULT_DECODE_WIDTH,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::DEFAULT_PHY_REG_NUM,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM),
  localparam type preg_t              = logic [PREG_W-1:0],
  // Same layout as in rename_stage
  localparam type rename_rsp_t = struct packed {
    preg_t psrc0;
    preg_t psrc1;
    preg_t ppdst;  // Previous dest mapping, kept by the ROB
    preg_t pdst;   // Freshly allocated dest
  }
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        rename_fire_i,  // Group present, already gated
  input  rename_pkg::rename_req_t [DECODE_WIDTH-1:0]  req_i,
  input  preg_t [DECODE_WIDTH-1:0]                    alloc_preg_i,   // From free list, per lane
  input  logic                                        restore_i,      // Flush cycle
  input  preg_t [rename_pkg::ARCH_REG_NUM-1:0]        arch_map_i,     // Committed table
  output rename_rsp_t [DECODE_WIDTH-1:0]              rsp_o
);
  import rename_pkg::*;

  preg_t [ARCH_REG_NUM-1:0] map_q;  // Speculative map
  logic  [DECODE_WIDTH-1:0] wen;    // Lane is last writer of its dest

  // ============================================================
  // Lookup with forwarding from earlier lanes
  // ============================================================
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      rsp_o[i].psrc0 = map_q[req_i[i].src0];
      rsp_o[i].psrc1 = map_q[req_i[i].src1];
      rsp_o[i].ppdst = map_q[req_i[i].dest];
      rsp_o[i].pdst  = alloc_preg_i[i];
      // Walk earlier lanes oldest first so the latest writer wins
      for (int j = 0; j < i; j++) begin
        if (req_i[j].valid && (req_i[j].dest == req_i[i].src0)) begin
          rsp_o[i].psrc0 = alloc_preg_i[j];  // RAW inside group
        end
        if (req_i[j].valid && (req_i[j].dest == req_i[i].src1)) begin
          rsp_o[i].psrc1 = alloc_preg_i[j];
        end
        if (req_i[j].valid && (req_i[j].dest == req_i[i].dest)) begin
          rsp_o[i].ppdst = alloc_preg_i[j];  // WAW, old mapping is the earlier lane
        end
      end
    end
  end

  // Only the youngest writer of a register updates the table
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      wen[i] = req_i[i].valid;
      for (int j = i + 1; j < DECODE_WIDTH; j++) begin
        if (req_i[j].valid && (req_i[j].dest == req_i[i].dest)) begin
          wen[i] = 1'b0;  // Overwritten later in group
        end
      end
    end
  end

  // ============================================================
  // Table update
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        map_q[r] <= preg_t'(r);  // Identity
      end
    end else if (restore_i) begin
      map_q <= arch_map_i;  // Flush wins over any write
    end else if (rename_fire_i) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (wen[i]) begin
          map_q[req_i[i].dest] <= alloc_preg_i[i];
        end
      end
    end
  end

  // Top must drop the group during a flush cycle
  a_no_fire_on_restore : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(restore_i && rename_fire_i)
  ) else $error("rename fired during restore");

endmodule : rename_map_table

// ==== hw/rename_pkg.sv ====
// Register rename package with widths, lane structs and flow-state encoding
package rename_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int unsigned ARCH_REG_NUM = 32;  // Architectural registers

  // Defaults for the module parameters, top level may override
  localparam int unsigned DEFAULT_DECODE_WIDTH = 2;
  localparam int unsigned DEFAULT_PHY_REG_NUM  = 64;

  // Widest physical index a commit lane can carry
  localparam int unsigned PREG_W_MAX = 8;  // Up to 256 physical regs

  typedef logic [$clog2(ARCH_REG_NUM)-1:0] areg_t;  // 5-bit arch index

  // ============================================================
  // Lane structs
  // ============================================================
  // One decoded instruction: dest = src0 op src1
  typedef struct packed {
    logic  valid;  // Lane writes a destination
    areg_t src0;
    areg_t src1;
    areg_t dest;
  } rename_req_t;

  // One retiring instruction from the ROB
  typedef struct packed {
    logic                  valid;
    areg_t                 dest;      // Arch reg being committed
    logic [PREG_W_MAX-1:0] preg;      // New committed mapping
    logic [PREG_W_MAX-1:0] old_preg;  // Previous mapping, goes back to free list
  } commit_t;

  // ============================================================
  // Flow state
  // ============================================================
  // RESTORE marks the single flush cycle
  typedef enum logic {
    RUN     = 1'b0,
    RESTORE = 1'b1
  } flow_state_e;

endpackage : rename_pkg
